// ==== compile.f ====
verilog/ilk_pkg.sv
verilog/ilk_ready_skid.sv
verilog/ilk_burst_framer.sv
verilog/ilk_tx_top.sv
dv/ilk_clk_gen.sv
dv/ilk_tx_assertions.sv
dv/ilk_tx_tb.sv

// ==== dv/ilk_clk_gen.sv ====
/*
  Clock and reset source for the testbench
  4 ns clock, reset held over the first 3 rising edges
*/

`timescale 1ns/100ps

module ilk_clk_gen (
	output logic clk,
	output logic arst
);

	// free running clock, rising edges at 2, 6, 10 ns and so on
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// release just after the third edge, clear of the sampling point
	initial begin
		arst = 1'b1;
		repeat (3) @(posedge clk);
		#0.5;
		arst = 1'b0;
	end

endmodule

// ==== dv/ilk_tx_assertions.sv ====
/*
  Handshake properties for the ready/valid skid stage
  stall hold, duplicate register agreement, backup slot protection,
  bound into every skid instance
*/

`timescale 1ns/100ps

module ilk_tx_assertions #(
	parameter int WIDTH = 16
) (
	input logic             clk,
	input logic             arst,
	input logic             valid_i,
	input logic             ready_i,
	input logic             valid_o,
	input logic [WIDTH-1:0] dat_o,
	input logic             ready_o,
	input logic             backup_valid_i,
	input logic             valid_dup_i,
	input logic             ready_dup_i
);

	// failure tally, summed by the testbench at the end of the run
	int err_cnt = 0;

	// a stalled word stays put until the sink takes it
	assert property (@(posedge clk) disable iff (arst)
		valid_o && !ready_o |=> valid_o && $stable(dat_o))
	else begin
		err_cnt++;
		$error("skid output changed while stalled");
	end

	// both copies of valid and ready must track each other
	assert property (@(posedge clk) disable iff (arst)
		valid_o == valid_dup_i && ready_i == ready_dup_i)
	else begin
		err_cnt++;
		$error("skid duplicate registers disagree");
	end

	// full backup slot means upstream is held off
	assert property (@(posedge clk) disable iff (arst)
		backup_valid_i |-> !(valid_i && ready_i))
	else begin
		err_cnt++;
		$error("skid accepted a word with the backup slot full");
	end

	// parked word survives the stall and the main word stays valid
	assert property (@(posedge clk) disable iff (arst)
		backup_valid_i && !ready_o |=> backup_valid_i && valid_o)
	else begin
		err_cnt++;
		$error("skid lost its parked word");
	end

endmodule

bind ilk_ready_skid ilk_tx_assertions #(.WIDTH(WIDTH)) u_skid_sva (
	.clk(clk),
	.arst(arst),
	.valid_i(valid_i),
	.ready_i(ready_i),
	.valid_o(valid_o),
	.dat_o(dat_o),
	.ready_o(ready_o),
	.backup_valid_i(backup_valid),
	.valid_dup_i(valid_dup),
	.ready_dup_i(ready_dup)
);

// ==== dv/ilk_tx_input.txt ====
# I sop eop chan data : source word    E is_ctl payload : expected framed word
# all fields hex, E lines in the order the sink must see them
I 1 1 05 0123456789abcdef
I 1 0 12 1111111122222222
I 0 0 12 00000000ffffffff
I 0 1 12 deadbeef00000000
I 1 0 3c 0000000000000000
I 0 0 3c a5a5a5a55a5a5a5a
I 0 0 3c 1234567800000000
I 0 1 3c 8765432100000000
E 1 4140000000000000
E 0 0123456789abcdef
E 1 8140006222222200
E 1 4480000000000000
E 0 1111111122222222
E 0 00000000ffffffff
E 0 deadbeef00000000
E 1 848000c4985c88c0
E 1 4f00000000000000
E 0 0000000000000000
E 0 a5a5a5a55a5a5a5a
E 0 1234567800000000
E 0 8765432100000000
E 1 8f00011aabbaa980

// ==== dv/ilk_tx_tb.sv ====
/*
  Testbench for the transmit framing path
  reads packet words and expected framed words from the data file,
  drives them under random sink back-pressure and checks the framed
  stream in order
*/

`timescale 1ns/100ps

module ilk_tx_tb;

	logic clk;
	logic arst;
	logic in_valid;
	ilk_pkg::ilk_in_word_t in_word;
	logic in_ready;
	logic out_valid;
	ilk_pkg::ilk_frame_word_t out_word;
	logic out_ready;

	// stimulus and reference stream from the data file
	ilk_pkg::ilk_in_word_t in_vec[$];
	ilk_pkg::ilk_frame_word_t exp_vec[$];
	int n_in;
	int n_exp;
	int exp_idx;
	int sva_errs;
	bit loaded;

	ilk_clk_gen u_clk_gen (
		.clk(clk),
		.arst(arst)
	);

	ilk_tx_top DUT (
		.clk(clk),
		.arst(arst),
		.in_valid_i(in_valid),
		.in_word_i(in_word),
		.in_ready_o(in_ready),
		.out_valid_o(out_valid),
		.out_word_o(out_word),
		.out_ready_i(out_ready)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_frame_word(input string name, input ilk_pkg::ilk_frame_word_t got,
		input ilk_pkg::ilk_frame_word_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0.1f ns: %s got %h expected %h",
				$realtime, name, got, exp));
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED at %0.1f ns: %s got %b expected %b",
				$realtime, name, got, exp));
	endtask

	// I lines are source words, E lines the framed words in order
	task automatic load_vectors();
		int fd;
		int n;
		string line;
		byte tag;
		logic [63:0] f0, f1, f2, f3;
		ilk_pkg::ilk_in_word_t iw;
		ilk_pkg::ilk_frame_word_t fw;
		fd = $fopen("dv/ilk_tx_input.txt", "r");
		if (fd == 0)
			fail_now("cannot open the stimulus file dv/ilk_tx_input.txt");
		while ($fgets(line, fd) > 0) begin
			tag = line.getc(0);
			if (tag == "I") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
				if (n != 4)
					fail_now($sformatf("malformed input line: %s", line));
				iw.sop = f0[0];
				iw.eop = f1[0];
				iw.chan = f2[ilk_pkg::CHAN_W-1:0];
				iw.data = f3;
				in_vec.push_back(iw);
			end else if (tag == "E") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f0, f1);
				if (n != 2)
					fail_now($sformatf("malformed expected line: %s", line));
				fw.is_ctl = f0[0];
				fw.payload.data = f1;
				exp_vec.push_back(fw);
			end
		end
		$fclose(fd);
		n_in = in_vec.size();
		n_exp = exp_vec.size();
	endtask

	// hold each word until the registered ready was high on an edge
	task automatic drive_words();
		int idx;
		logic took;
		idx = 0;
		while (idx < n_in) begin
			in_valid = 1'b1;
			in_word = in_vec[idx];
			@(negedge clk);
			took = in_ready;
			@(posedge clk);
			#0.5;
			if (took)
				idx++;
		end
		in_valid = 1'b0;
		in_word = '0;
	endtask

	// sink ready is low about 30% of cycles
	initial begin
		out_ready = 1'b0;
		void'($urandom(32'h7110));
		forever begin
			@(posedge clk);
			#0.5;
			out_ready = ($urandom % 100) >= 30;
		end
	end

	// output side, sampled mid-cycle where everything is settled
	initial begin
		exp_idx = 0;
		forever begin
			@(negedge clk);
			if (!arst && out_valid && out_ready) begin
				if (exp_idx >= n_exp)
					fail_now("DUT sent a framed word beyond the expected stream");
				check_frame_word("out_word_o", out_word, exp_vec[exp_idx]);
				exp_idx++;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (40 * n_in + 200) @(posedge clk);
		$display("timeout: only %0d of %0d framed words arrived", exp_idx, n_exp);
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		int k;
		in_valid = 1'b0;
		in_word = '0;
		load_vectors();
		loaded = 1'b1;

		// both handshake outputs idle straight out of reset
		@(negedge arst);
		#1;
		check_ready("in_ready_o", in_ready, 1'b0);
		check_ready("out_valid_o", out_valid, 1'b0);
		k = 0;
		while (!in_ready && k < 10) begin
			@(negedge clk);
			k++;
		end
		check_ready("in_ready_o", in_ready, 1'b1);

		@(posedge clk);
		#0.5;
		drive_words();
		wait (exp_idx == n_exp);

		// idle a while so any extra word is caught
		repeat (20) @(posedge clk);
		sva_errs = DUT.u_in_skid.u_skid_sva.err_cnt + DUT.u_out_skid.u_skid_sva.err_cnt;
		if (sva_errs != 0) begin
			$display("%0d skid handshake assertion failures", sva_errs);
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the transmit framing testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ilk_tx_tb -Mdir obj_dir
out=$(./obj_dir/Vilk_tx_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

// ==== verilog/ilk_burst_framer.sv ====
/*
  Burst framer for the transmit path
  wraps each packet in a start and an end control word,
  counts the packet words and folds them into an XOR checksum
  that the end word carries
*/

`timescale 1ns/100ps

module ilk_burst_framer (
	input  logic                     clk,
	input  logic                     arst,

	// packet words from the input skid buffer
	input  logic                     in_valid_i,
	input  ilk_pkg::ilk_in_word_t    in_word_i,
	output logic                     in_ready_o,

	// framed words toward the output skid buffer
	output logic                     out_valid_o,
	output ilk_pkg::ilk_frame_word_t out_word_o,
	input  logic                     out_ready_i
);

	// S_DATA   idle between packets or passing packet data
	// S_START  start word issued, waiting to take the sop data word
	// S_END    eop data word issued, end word goes out next
	typedef enum logic [1:0] {
		S_DATA  = 2'd0,
		S_START = 2'd1,
		S_END   = 2'd2
	} state_e;

	state_e state;

	// output register is free now or empties on this edge
	logic can_load;
	logic load_start;
	logic load_end;
	logic in_fire;

	// per-packet channel, word count and checksum
	logic [ilk_pkg::CHAN_W-1:0] chan_q;
	logic [ilk_pkg::CNT_W-1:0]  cnt_q;
	logic [ilk_pkg::CSUM_W-1:0] csum_q;

	// incoming data word folded to checksum width
	logic [ilk_pkg::CSUM_W-1:0] in_fold;

	// builds a control word, reserved bits are zero
	function automatic ilk_pkg::ilk_frame_word_t make_ctl(
		input ilk_pkg::ctl_type_e         kind,
		input logic [ilk_pkg::CHAN_W-1:0] chan,
		input logic [ilk_pkg::CNT_W-1:0]  cnt,
		input logic [ilk_pkg::CSUM_W-1:0] csum
	);
		ilk_pkg::ilk_frame_word_t w;
		w.is_ctl = 1'b1;
		w.payload.ctl.ctl_type = kind;
		w.payload.ctl.chan = chan;
		w.payload.ctl.count = cnt;
		w.payload.ctl.csum = csum;
		w.payload.ctl.rsvd = '0;
		return w;
	endfunction

	assign in_fold = in_word_i.data[ilk_pkg::DATA_W-1:ilk_pkg::CSUM_W] ^
		in_word_i.data[ilk_pkg::CSUM_W-1:0];

	assign can_load = !out_valid_o || out_ready_i;

	// a sop word waiting in S_DATA triggers the start word first
	assign load_start = (state == S_DATA) && can_load && in_valid_i && in_word_i.sop;
	assign load_end = (state == S_END) && can_load;

	// input is blocked while a control word is being inserted
	always_comb begin
		case (state)
			S_DATA:  in_ready_o = can_load && !(in_valid_i && in_word_i.sop);
			S_START: in_ready_o = can_load;
			default: in_ready_o = 1'b0;
		endcase
	end

	assign in_fire = in_valid_i && in_ready_o;

	// state and output valid
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= S_DATA;
			out_valid_o <= 1'b0;
		end else begin
			if (out_valid_o && out_ready_i)
				out_valid_o <= 1'b0;
			if (load_start || load_end || in_fire)
				out_valid_o <= 1'b1;

			case (state)
				S_DATA: begin
					if (load_start)
						state <= S_START;
					else if (in_fire && in_word_i.eop)
						state <= S_END;
				end
				S_START: begin
					// single-word packets go straight to the end insert
					if (in_fire)
						state <= in_word_i.eop ? S_END : S_DATA;
				end
				default: begin
					if (load_end)
						state <= S_DATA;
				end
			endcase
		end
	end

	// output word and packet accumulators
	always_ff @(posedge clk) begin
		if (load_start) begin
			out_word_o <= make_ctl(ilk_pkg::CTL_START, in_word_i.chan, '0, '0);
		end else if (load_end) begin
			out_word_o <= make_ctl(ilk_pkg::CTL_END, chan_q, cnt_q, csum_q);
		end else if (in_fire) begin
			out_word_o.is_ctl <= 1'b0;
			out_word_o.payload.data <= in_word_i.data;
		end

		if (in_fire) begin
			// sop restarts the count and the checksum
			if (in_word_i.sop) begin
				chan_q <= in_word_i.chan;
				cnt_q <= ilk_pkg::CNT_W'(1);
				csum_q <= in_fold;
			end else begin
				cnt_q <= cnt_q + 1'b1;
				csum_q <= csum_q ^ in_fold;
			end
		end
	end

endmodule

// ==== verilog/ilk_pkg.sv ====
/*
  Shared definitions for the transmit burst framing path
  field widths, input word struct, control word kinds and layout,
  framed output word with its data or control payload view
*/

package ilk_pkg;

	// payload and tag widths
	localparam int DATA_W = 64;
	localparam int CHAN_W = 8;
	localparam int CNT_W = 16;

	// checksum is the 64-bit word folded to 32 bits, then XORed over the packet
	localparam int CSUM_W = 32;

	// reserved bits that pad the control word out to DATA_W
	localparam int CTL_RSVD_W = DATA_W - 2 - CHAN_W - CNT_W - CSUM_W;

	// one word from the packet source
	// sop and eop may both be set on a single-word packet
	typedef struct packed {
		logic              sop;
		logic              eop;
		logic [CHAN_W-1:0] chan;
		logic [DATA_W-1:0] data;
	} ilk_in_word_t;

	// control word kinds
	// 2'b00 and 2'b11 are not produced by the framer
	typedef enum logic [1:0] {
		CTL_START = 2'b01,
		CTL_END   = 2'b10
	} ctl_type_e;

	// control word layout, msb first
	// count and checksum are only meaningful in an end word
	typedef struct packed {
		ctl_type_e             ctl_type;
		logic [CHAN_W-1:0]     chan;
		logic [CNT_W-1:0]      count;
		logic [CSUM_W-1:0]     csum;
		logic [CTL_RSVD_W-1:0] rsvd;
	} ilk_ctl_t;

	// the same 64 bits read as plain data or as a control word,
	// selected by is_ctl in the framed word
	typedef union packed {
		logic [DATA_W-1:0] data;
		ilk_ctl_t          ctl;
	} ilk_payload_u;

	// framed stream word toward the sink
	typedef struct packed {
		logic         is_ctl;
		ilk_payload_u payload;
	} ilk_frame_word_t;

endpackage

// ==== verilog/ilk_ready_skid.sv ====
/*
  Ready/valid pipeline stage with a registered ready
  one backup word catches the word in flight when downstream stalls
  valid and ready registers are kept twice to split fanout
*/

`timescale 1ns/100ps

module ilk_ready_skid #(
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             arst,

	// upstream side
	input  logic             valid_i,
	input  logic [WIDTH-1:0] dat_i,
	output logic             ready_i,

	// downstream side
	output logic             valid_o,
	output logic [WIDTH-1:0] dat_o,
	input  logic             ready_o
);

	// backup slot for the word accepted while downstream stalls
	logic [WIDTH-1:0] backup_dat;
	logic             backup_valid;

	// internal copies of valid_o and ready_i
	// the outputs drive the neighbours, the copies drive local logic
	logic             valid_dup;
	logic             ready_dup;

	// handshake state
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			ready_i <= 1'b0;
			ready_dup <= 1'b0;
			valid_o <= 1'b0;
			valid_dup <= 1'b0;
			backup_valid <= 1'b0;
		end else begin
			// upstream ready trails downstream ready by one clock
			ready_i <= ready_o;
			ready_dup <= ready_o;

			if (valid_dup && ready_o) begin
				// main word leaves, refill from backup if it holds one
				if (backup_valid) begin
					backup_valid <= 1'b0;
					valid_o <= 1'b1;
					valid_dup <= 1'b1;
				end else begin
					valid_o <= 1'b0;
					valid_dup <= 1'b0;
				end
			end

			if (ready_dup && valid_i) begin
				if (ready_o || !valid_dup) begin
					valid_o <= 1'b1;
					valid_dup <= 1'b1;
				end else begin
					// main register is stuck, park the word and stop upstream
					backup_valid <= 1'b1;
					ready_i <= 1'b0;
					ready_dup <= 1'b0;
				end
			end
		end
	end

	// data path, follows the same decisions as above
	always_ff @(posedge clk) begin
		if (valid_dup && ready_o && backup_valid)
			dat_o <= backup_dat;
		if (ready_dup && valid_i) begin
			if (ready_o || !valid_dup)
				dat_o <= dat_i;
			else
				backup_dat <= dat_i;
		end
	end

endmodule

// ==== verilog/ilk_tx_top.sv ====
/*
  Transmit framing path top
  input skid buffer, burst framer, output skid buffer
*/

`timescale 1ns/100ps

module ilk_tx_top (
	input  logic                     clk,
	input  logic                     arst,

	// packet source
	input  logic                     in_valid_i,
	input  ilk_pkg::ilk_in_word_t    in_word_i,
	output logic                     in_ready_o,

	// framed stream to the sink
	output logic                     out_valid_o,
	output ilk_pkg::ilk_frame_word_t out_word_o,
	input  logic                     out_ready_i
);

	// input skid to framer
	logic                     skid_valid;
	ilk_pkg::ilk_in_word_t    skid_word;
	logic                     framer_ready;

	// framer to output skid
	logic                     frame_valid;
	ilk_pkg::ilk_frame_word_t frame_word;
	logic                     out_skid_ready;

	// registers the source side, ready to the source is one clock late
	ilk_ready_skid #(
		.WIDTH($bits(ilk_pkg::ilk_in_word_t))
	) u_in_skid (
		.clk(clk),
		.arst(arst),
		.valid_i(in_valid_i),
		.dat_i(in_word_i),
		.ready_i(in_ready_o),
		.valid_o(skid_valid),
		.dat_o(skid_word),
		.ready_o(framer_ready)
	);

	ilk_burst_framer u_framer (
		.clk(clk),
		.arst(arst),
		.in_valid_i(skid_valid),
		.in_word_i(skid_word),
		.in_ready_o(framer_ready),
		.out_valid_o(frame_valid),
		.out_word_o(frame_word),
		.out_ready_i(out_skid_ready)
	);

	// registers the sink side, so sink ready never reaches the framer directly
	ilk_ready_skid #(
		.WIDTH($bits(ilk_pkg::ilk_frame_word_t))
	) u_out_skid (
		.clk(clk),
		.arst(arst),
		.valid_i(frame_valid),
		.dat_i(frame_word),
		.ready_i(out_skid_ready),
		.valid_o(out_valid_o),
		.dat_o(out_word_o),
		.ready_o(out_ready_i)
	);

endmodule
